// ==== filelist.f ====
+incdir+source
source/conv_pkg.sv
source/sync_ram.sv
source/conv_pe.sv
source/conv_sequencer.sv
source/result_collector.sv
source/conv_top.sv
sim/conv_properties.sv
sim/conv_tb.sv

// ==== sim/conv_cases.txt ====
# name  w00 w01 w02 w10 w11 w12 w20 w21 w22  base row_step col_step
#       weights_only writes_in_busy start_in_busy  count  total
ext_neg -128 -128 -128 -128 -128 -128 -128 -128 -128 255 0 0 0 0 0 36 -10575360
ext_pos 127 127 127 127 127 127 127 127 127 0 0 0 1 0 0 36 10492740
ramp 1 -2 3 -4 5 -6 7 -8 9 0 8 1 0 0 0 36 7470
kernel_swap -1 0 1 -2 0 2 -1 0 1 0 0 0 1 0 0 36 288
busy_writes 2 -1 0 3 1 -3 0 4 -2 17 5 3 0 1 0 36 5580
busy_start 1 1 1 1 1 1 1 1 1 0 0 0 1 0 1 36 14580

// ==== sim/conv_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_properties (
    input wire clk,
    input wire rst,
    input wire i_busy,
    input wire i_done,
    input wire i_res_valid
);

    ////////////////////////////////////////////////////////////
    // Run protocol at the top level
    ////////////////////////////////////////////////////////////

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        i_done |=> !i_done)
        else $error("o_done held longer than one cycle");

    valid_in_busy: assert property (@(posedge clk) disable iff (rst)
        i_res_valid |-> i_busy)
        else $error("o_res_valid outside a run");

    // Done only closes a run
    done_after_busy: assert property (@(posedge clk) disable iff (rst)
        i_done |-> $past(i_busy))
        else $error("o_done without a preceding busy cycle");

    busy_falls_with_done: assert property (@(posedge clk) disable iff (rst)
        $fell(i_busy) |-> i_done)
        else $error("o_busy fell without o_done");

endmodule

bind conv_top conv_properties props_i (
    .clk         (clk),
    .rst         (rst),
    .i_busy      (o_busy),
    .i_done      (o_done),
    .i_res_valid (o_res_valid)
);

`default_nettype wire

// ==== sim/conv_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_tb import conv_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int KK         = `CONV_KERNEL * `CONV_KERNEL;
    localparam int OUT_W      = `CONV_FEAT_W - `CONV_KERNEL + 1;
    localparam int OUT_H      = `CONV_FEAT_H - `CONV_KERNEL + 1;
    localparam int NOUT       = OUT_W * OUT_H;
    localparam int NPIX       = `CONV_FEAT_W * `CONV_FEAT_H;
    localparam int GROUP_CYC  = `CONV_NUM_PE * KK + KK + `CONV_NUM_PE + 8;
    localparam int WRITE_CYC  = NPIX + KK + 8;
    localparam int MAX_CASES  = 16;

    // Sum over a whole run, wider than one result
    typedef logic signed [2*`CONV_ACC_W-1:0] total_t;

    logic       clk;
    logic       rst;
    logic       i_wr;
    logic       i_wr_sel;
    feat_addr_t i_wr_addr;
    word_t      i_wr_data;
    logic       i_start;
    logic       o_busy;
    logic       o_done;
    logic       o_res_valid;
    acc_t       o_res_data;

    string   case_name [MAX_CASES];
    int      case_wgt [MAX_CASES][KK];
    int      case_fill [MAX_CASES][3];
    logic    case_wonly [MAX_CASES];
    logic    case_wbusy [MAX_CASES];
    logic    case_sbusy [MAX_CASES];
    int      case_count [MAX_CASES];
    int      case_total [MAX_CASES];
    int      n_cases = 0;
    int      errors = 0;
    int      watchdog_cycles = 0;
    logic    cases_ready = 1'b0;
    acc_t    results [$];
    int      done_count = 0;
    pixel_t  pix_model [NPIX];
    weight_t wgt_model [KK];

    conv_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .i_wr        (i_wr),
        .i_wr_sel    (i_wr_sel),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_start     (i_start),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_res_valid (o_res_valid),
        .o_res_data  (o_res_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Output stream monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (o_res_valid) begin
                results.push_back(o_res_data);
            end
            if (o_done) begin
                done_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_acc(input string what, input acc_t exp, input acc_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("error %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_total(input string what, input total_t exp, input total_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and stimulus
    ////////////////////////////////////////////////////////////

    function automatic int expected_out(input int r, input int c);
        int acc;
        int ky;
        int kx;
        acc = 0;
        for (ky = 0; ky < `CONV_KERNEL; ky++) begin
            for (kx = 0; kx < `CONV_KERNEL; kx++) begin
                acc += int'(pix_model[(r + ky) * `CONV_FEAT_W + c + kx])
                       * int'(wgt_model[ky * `CONV_KERNEL + kx]);
            end
        end
        return acc;
    endfunction

    task automatic read_cases();
        int    fd;
        int    got;
        int    k;
        int    f [17];
        string line;
        string name;
        fd = $fopen("sim/conv_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the case file sim/conv_cases.txt");
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                got = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                              name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                              f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (got == 18) begin
                    case_name[n_cases] = name;
                    for (k = 0; k < KK; k++) begin
                        case_wgt[n_cases][k] = f[k];
                    end
                    for (k = 0; k < 3; k++) begin
                        case_fill[n_cases][k] = f[9 + k];
                    end
                    case_wonly[n_cases] = (f[12] != 0);
                    case_wbusy[n_cases] = (f[13] != 0);
                    case_sbusy[n_cases] = (f[14] != 0);
                    case_count[n_cases] = f[15];
                    case_total[n_cases] = f[16];
                    n_cases++;
                end else begin
                    errors++;
                    $display("malformed line in the case file: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic write_word(input logic sel, input feat_addr_t addr, input word_t data);
        @(posedge clk);
        i_wr      <= 1'b1;
        i_wr_sel  <= sel;
        i_wr_addr <= addr;
        i_wr_data <= data;
    endtask

    task automatic run_and_check(input int idx, input logic busy_writes, input logic busy_start);
        int     done_before;
        int     k;
        total_t sum;
        string  name;
        name = case_name[idx];
        results.delete();
        done_before = done_count;
        @(posedge clk);
        i_wr    <= 1'b0;
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        if (busy_start) begin
            repeat (20) @(posedge clk);
            i_start <= 1'b1;
            @(posedge clk);
            i_start <= 1'b0;
        end
        if (busy_writes) begin
            // Random traffic to both memories while the engine runs
            repeat (40) begin
                @(posedge clk);
                i_wr      <= 1'b1;
                i_wr_sel  <= 1'($urandom_range(1, 0));
                i_wr_addr <= feat_addr_t'($urandom);
                i_wr_data <= word_t'($urandom);
            end
            @(posedge clk);
            i_wr <= 1'b0;
        end
        while (done_count == done_before) @(negedge clk);
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_count({name, " count"}, case_count[idx], results.size());
        check_count({name, " done pulses"}, 1, done_count - done_before);
        check_flag({name, " busy after run"}, 1'b0, o_busy);
        sum = '0;
        for (k = 0; k < results.size(); k++) begin
            if (k < NOUT) begin
                check_acc($sformatf("%s out %0d", name, k),
                          acc_t'(expected_out(k / OUT_W, k % OUT_W)), results[k]);
            end
            sum += total_t'(results[k]);
        end
        check_total({name, " total"}, total_t'(case_total[idx]), sum);
    endtask

    task automatic run_case(input int idx);
        int a;
        if (!case_wonly[idx]) begin
            for (a = 0; a < NPIX; a++) begin
                pix_model[a] = pixel_t'((case_fill[idx][0] + (a / `CONV_FEAT_W) * case_fill[idx][1]
                                         + (a % `CONV_FEAT_W) * case_fill[idx][2]) & 255);
                write_word(1'b0, feat_addr_t'(a), word_t'(pix_model[a]));
            end
        end
        for (a = 0; a < KK; a++) begin
            wgt_model[a] = weight_t'(case_wgt[idx][a]);
            write_word(1'b1, feat_addr_t'(a), word_t'(wgt_model[a]));
        end
        run_and_check(idx, case_wbusy[idx], case_sbusy[idx]);
        // Second run shows the busy writes left both memories alone
        if (case_wbusy[idx]) begin
            run_and_check(idx, 1'b0, 1'b0);
        end
    endtask

    initial begin : watchdog
        wait (cases_ready);
        #(watchdog_cycles * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        int n_tests;
        int n_failed;
        int errs_before;
        int t;
        void'($urandom(9));
        rst       = 1'b1;
        i_wr      = 1'b0;
        i_wr_sel  = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_start   = 1'b0;
        n_tests   = 0;
        n_failed  = 0;
        read_cases();
        watchdog_cycles = n_cases * (GROUP_CYC * (NOUT / `CONV_NUM_PE) + WRITE_CYC) * 2 + 200;
        cases_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Idle after reset, nothing may come out
        errs_before = errors;
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_flag("reset_idle busy", 1'b0, o_busy);
        check_flag("reset_idle done", 1'b0, o_done);
        check_flag("reset_idle valid", 1'b0, o_res_valid);
        check_count("reset_idle results", 0, results.size());
        check_count("reset_idle done pulses", 0, done_count);
        n_tests++;
        n_failed += (errors != errs_before);
        $display("%-12s %s", "reset_idle", (errors == errs_before) ? "pass" : "fail");

        for (t = 0; t < n_cases; t++) begin
            errs_before = errors;
            run_case(t);
            n_tests++;
            n_failed += (errors != errs_before);
            $display("%-12s %s", case_name[t], (errors == errs_before) ? "pass" : "fail");
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - n_failed, n_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/conv_defs.svh ====
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

////////////////////////////////////////////////////////////
// Map and kernel geometry
////////////////////////////////////////////////////////////

`define CONV_FEAT_W   8
`define CONV_FEAT_H   8
`define CONV_KERNEL   3

// Engines working on one group
`define CONV_NUM_PE   4

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////

`define CONV_PIX_W    8
`define CONV_WGT_W    8
`define CONV_ACC_W    20
`define CONV_FEAT_AW  6
`define CONV_WIN_AW   4

`endif

// ==== source/conv_pe.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_pe import conv_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             i_wgt_wr,
    input  wire win_addr_t  i_wgt_addr,
    input  wire weight_t    i_wgt_data,
    input  wire             i_win_wr,
    input  wire win_addr_t  i_win_addr,
    input  wire pixel_t     i_win_data,
    input  wire             i_start,
    output logic            o_done,
    output acc_t            o_sum
);

    localparam int        KK       = `CONV_KERNEL * `CONV_KERNEL;
    localparam win_addr_t LAST_IDX = win_addr_t'(KK - 1);

    logic      running;
    win_addr_t mac_idx;
    win_addr_t rd_idx;
    win_addr_t wgt_addr;
    win_addr_t win_addr;
    weight_t   wgt_q;
    pixel_t    pix_q;
    logic signed [`CONV_PIX_W+`CONV_WGT_W:0] prod;

    // Fetch runs one element ahead of the adder, idle parks on element 0
    assign rd_idx   = (running && mac_idx != LAST_IDX) ? mac_idx + 1'b1 : '0;
    assign wgt_addr = i_wgt_wr ? i_wgt_addr : rd_idx;
    assign win_addr = i_win_wr ? i_win_addr : rd_idx;

    sync_ram #(
        .T     (weight_t),
        .DEPTH (KK)
    ) wgt_ram_i (
        .clk     (clk),
        .i_wr    (i_wgt_wr),
        .i_addr  (wgt_addr),
        .i_wdata (i_wgt_data),
        .o_rdata (wgt_q)
    );

    sync_ram #(
        .T     (pixel_t),
        .DEPTH (KK)
    ) win_ram_i (
        .clk     (clk),
        .i_wr    (i_win_wr),
        .i_addr  (win_addr),
        .i_wdata (i_win_data),
        .o_rdata (pix_q)
    );

    // Pixel is zero extended so the product stays signed
    assign prod = $signed({1'b0, pix_q}) * wgt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            mac_idx <= '0;
            o_done  <= 1'b0;
        end else if (i_start) begin
            running <= 1'b1;
            mac_idx <= '0;
            o_done  <= 1'b0;
        end else if (running) begin
            mac_idx <= mac_idx + 1'b1;
            if (mac_idx == LAST_IDX) begin
                running <= 1'b0;
                o_done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_sum <= '0;
        end else if (running) begin
            o_sum <= o_sum + acc_t'(prod);
        end
    end

endmodule

`default_nettype wire

// ==== source/conv_pkg.sv ====
`default_nettype none

`include "conv_defs.svh"

package conv_pkg;

    // Host side word, stored as pixel or weight
    typedef logic [`CONV_PIX_W-1:0] word_t;

    // Feature map sample, unsigned
    typedef logic [`CONV_PIX_W-1:0] pixel_t;

    // Kernel coefficient, two's complement
    typedef logic signed [`CONV_WGT_W-1:0] weight_t;

    // Full precision sum of KERNEL^2 products
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // Feature map address, also the host address
    typedef logic [`CONV_FEAT_AW-1:0] feat_addr_t;

    // Window element or kernel index, ky*KERNEL+kx
    typedef logic [`CONV_WIN_AW-1:0] win_addr_t;

endpackage

`default_nettype wire

// ==== source/conv_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_sequencer import conv_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       i_wr,
    input  wire                       i_wr_sel,
    input  wire feat_addr_t           i_wr_addr,
    input  wire word_t                i_wr_data,
    input  wire                       i_start,
    input  wire                       i_group_done,
    output logic                      o_busy,
    output logic                      o_done,
    output logic                      o_wgt_wr,
    output win_addr_t                 o_wgt_addr,
    output weight_t                   o_wgt_data,
    output logic [`CONV_NUM_PE-1:0]   o_win_wr,
    output win_addr_t                 o_win_addr,
    output pixel_t                    o_win_data,
    output logic                      o_pe_start
);

    localparam int OUT_W = `CONV_FEAT_W - `CONV_KERNEL + 1;
    localparam int OUT_H = `CONV_FEAT_H - `CONV_KERNEL + 1;
    localparam int PE_IW = (`CONV_NUM_PE > 1) ? $clog2(`CONV_NUM_PE) : 1;
    localparam int KW    = (`CONV_KERNEL > 1) ? $clog2(`CONV_KERNEL) : 1;

    localparam logic [PE_IW-1:0] PE_LAST = PE_IW'(`CONV_NUM_PE - 1);
    localparam logic [KW-1:0]    K_LAST  = KW'(`CONV_KERNEL - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_COMPUTE,
        S_FINISH
    } state_t;

    state_t           state;
    feat_addr_t       base_r, base_c;
    feat_addr_t       pe_r, pe_c;
    feat_addr_t       next_r, next_c;
    feat_addr_t       load_addr, ram_addr;
    logic [PE_IW-1:0] pe_idx, rd_pe_q;
    logic [KW-1:0]    ky, kx;
    win_addr_t        rd_win_q;
    logic             rd_valid_q, rd_last_q;
    logic             load_last, start_ok, feat_wr;

    assign o_busy   = (state == S_LOAD) || (state == S_COMPUTE);
    assign o_done   = (state == S_FINISH);
    assign start_ok = i_start && !i_wr && !o_busy;

    ////////////////////////////////////////////////////////////
    // Host writes, only while not busy
    ////////////////////////////////////////////////////////////

    assign feat_wr    = i_wr && !i_wr_sel && !o_busy;
    assign o_wgt_wr   = i_wr && i_wr_sel && !o_busy;
    assign o_wgt_addr = i_wr_addr[`CONV_WIN_AW-1:0];
    assign o_wgt_data = weight_t'(i_wr_data);

    // Output position of this PE, may spill into the next row
    always_comb begin
        pe_c = base_c + feat_addr_t'(pe_idx);
        pe_r = base_r;
        if (pe_c >= feat_addr_t'(OUT_W)) begin
            pe_c = pe_c - feat_addr_t'(OUT_W);
            pe_r = base_r + 1'b1;
        end
        next_c = base_c + feat_addr_t'(`CONV_NUM_PE);
        next_r = base_r;
        if (next_c >= feat_addr_t'(OUT_W)) begin
            next_c = next_c - feat_addr_t'(OUT_W);
            next_r = base_r + 1'b1;
        end
    end

    assign load_addr = feat_addr_t'((pe_r + ky) * `CONV_FEAT_W + pe_c + kx);
    assign ram_addr  = feat_wr ? i_wr_addr : load_addr;
    assign load_last = (state == S_LOAD) && (kx == K_LAST) && (ky == K_LAST)
                       && (pe_idx == PE_LAST);

    sync_ram #(
        .T     (pixel_t),
        .DEPTH (`CONV_FEAT_W * `CONV_FEAT_H)
    ) feat_ram_i (
        .clk     (clk),
        .i_wr    (feat_wr),
        .i_addr  (ram_addr),
        .i_wdata (pixel_t'(i_wr_data)),
        .o_rdata (o_win_data)
    );

    ////////////////////////////////////////////////////////////
    // Run control and window walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            base_r     <= '0;
            base_c     <= '0;
            pe_idx     <= '0;
            ky         <= '0;
            kx         <= '0;
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            o_pe_start <= 1'b0;
        end else begin
            rd_valid_q <= (state == S_LOAD);
            rd_last_q  <= load_last;
            // Start goes out once the last window word is written
            o_pe_start <= rd_last_q;
            case (state)
                S_IDLE, S_FINISH: begin
                    state <= S_IDLE;
                    if (start_ok) begin
                        state  <= S_LOAD;
                        base_r <= '0;
                        base_c <= '0;
                        pe_idx <= '0;
                        ky     <= '0;
                        kx     <= '0;
                    end
                end
                S_LOAD: begin
                    if (kx == K_LAST) begin
                        kx <= '0;
                        if (ky == K_LAST) begin
                            ky <= '0;
                            if (pe_idx == PE_LAST) begin
                                pe_idx <= '0;
                                state  <= S_COMPUTE;
                            end else begin
                                pe_idx <= pe_idx + 1'b1;
                            end
                        end else begin
                            ky <= ky + 1'b1;
                        end
                    end else begin
                        kx <= kx + 1'b1;
                    end
                end
                S_COMPUTE: begin
                    if (i_group_done) begin
                        base_r <= next_r;
                        base_c <= next_c;
                        state  <= (next_r == feat_addr_t'(OUT_H)) ? S_FINISH : S_LOAD;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Read latency alignment for the window write
    always_ff @(posedge clk) begin
        rd_pe_q  <= pe_idx;
        rd_win_q <= win_addr_t'(ky * `CONV_KERNEL + kx);
    end

    assign o_win_addr = rd_win_q;

    always_comb begin
        o_win_wr = '0;
        if (rd_valid_q) begin
            o_win_wr[rd_pe_q] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/conv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module conv_top import conv_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             i_wr,
    input  wire             i_wr_sel,
    input  wire feat_addr_t i_wr_addr,
    input  wire word_t      i_wr_data,
    input  wire             i_start,
    output logic            o_busy,
    output logic            o_done,
    output logic            o_res_valid,
    output acc_t            o_res_data
);

    wire                      wgt_wr;
    wire win_addr_t           wgt_addr;
    wire weight_t             wgt_data;
    wire [`CONV_NUM_PE-1:0]   win_wr;
    wire win_addr_t           win_addr;
    wire pixel_t              win_data;
    wire                      pe_start;
    wire                      group_done;
    wire [`CONV_NUM_PE-1:0]   pe_done;
    wire acc_t                pe_sum [`CONV_NUM_PE];

    conv_sequencer seq_i (
        .clk          (clk),
        .rst          (rst),
        .i_wr         (i_wr),
        .i_wr_sel     (i_wr_sel),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .i_start      (i_start),
        .i_group_done (group_done),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_wgt_wr     (wgt_wr),
        .o_wgt_addr   (wgt_addr),
        .o_wgt_data   (wgt_data),
        .o_win_wr     (win_wr),
        .o_win_addr   (win_addr),
        .o_win_data   (win_data),
        .o_pe_start   (pe_start)
    );

    ////////////////////////////////////////////////////////////
    // Engine array, weights broadcast, windows one-hot
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `CONV_NUM_PE; g++) begin : g_pe
        conv_pe pe_i (
            .clk        (clk),
            .rst        (rst),
            .i_wgt_wr   (wgt_wr),
            .i_wgt_addr (wgt_addr),
            .i_wgt_data (wgt_data),
            .i_win_wr   (win_wr[g]),
            .i_win_addr (win_addr),
            .i_win_data (win_data),
            .i_start    (pe_start),
            .o_done     (pe_done[g]),
            .o_sum      (pe_sum[g])
        );
    end

    result_collector coll_i (
        .clk          (clk),
        .rst          (rst),
        .i_pe_done    (pe_done),
        .i_pe_sum     (pe_sum),
        .o_res_valid  (o_res_valid),
        .o_res_data   (o_res_data),
        .o_group_done (group_done)
    );

endmodule

`default_nettype wire

// ==== source/result_collector.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_defs.svh"

module result_collector import conv_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    input  wire [`CONV_NUM_PE-1:0]    i_pe_done,
    input  wire acc_t                 i_pe_sum [`CONV_NUM_PE],
    output logic                      o_res_valid,
    output acc_t                      o_res_data,
    output logic                      o_group_done
);

    localparam int               PE_IW   = (`CONV_NUM_PE > 1) ? $clog2(`CONV_NUM_PE) : 1;
    localparam logic [PE_IW-1:0] PE_LAST = PE_IW'(`CONV_NUM_PE - 1);

    acc_t             sum_q [`CONV_NUM_PE];
    logic [PE_IW-1:0] out_idx;
    logic             armed;
    logic             all_done;
    logic             capture;

    assign all_done = &i_pe_done;
    assign capture  = armed && !o_res_valid && all_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed        <= 1'b1;
            o_res_valid  <= 1'b0;
            out_idx      <= '0;
            o_group_done <= 1'b0;
        end else begin
            o_group_done <= 1'b0;
            if (capture) begin
                armed       <= 1'b0;
                o_res_valid <= 1'b1;
                out_idx     <= '0;
            end else if (o_res_valid) begin
                out_idx <= out_idx + 1'b1;
                if (out_idx == PE_LAST) begin
                    o_res_valid  <= 1'b0;
                    o_group_done <= 1'b1;
                end
            end
            // Dones drop on the next PE start
            if (!all_done) begin
                armed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            sum_q <= i_pe_sum;
        end
    end

    // PE order within the group is raster order
    assign o_res_data = sum_q[out_idx];

endmodule

`default_nettype wire

// ==== source/sync_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_ram import conv_pkg::*; #(
    parameter type T     = pixel_t,
    parameter int  DEPTH = 16
) (
    input  wire                       clk,
    input  wire                       i_wr,
    input  wire [$clog2(DEPTH)-1:0]   i_addr,
    input  wire T                     i_wdata,
    output T                          o_rdata
);

    T                       mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[i_addr] <= i_wdata;
        end
        addr_q <= i_addr;
    end

    // Read port sees the address of the previous cycle
    assign o_rdata = mem[addr_q];

endmodule

`default_nettype wire
